/* vlog.f */
+incdir+common
common/rx_mac_pkg.sv
rtl/frame/rx_lane_decode.sv
rtl/frame/rx_beat_pacer.sv
rtl/frame/rx_framer.sv
rtl/frame/rx_byte_counter.sv
rtl/rx_link_monitor.sv
rtl/rx_mac_top.sv
verif/tb_clk_gen.sv
verif/tb_rx_mac.sv

/* verif/tb_rx_mac.sv */
//**************************************************************************
// table driven testbench for the receive MAC with one row per frame or link event
// expected beats and records are queued at drive time and popped on each pulse
//**************************************************************************
`include "rx_mac_macros.svh"

module tb_rx_mac;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int SLOT_LANES  = `RX_LANES / `RX_START_SLOTS;
	localparam int GAP_BEATS   = 2;      // idle beats after every row
	localparam int FAULT_BEATS = 3;
	localparam int OUT_LAT     = 3;      // first beat cycle to registered write

	// -1 marks an unused lane or slot in a table row
	typedef struct packed {
		rx_mac_pkg::rx_mode_t         mode;
		logic                         init_done;
		int                           start_slot;
		int                           mid_beats;
		logic                         same_beat;
		int                           term_lane;
		int                           fault_lane;
		logic [`RX_LEN_W-1:0]         exp_len;
		logic [`RX_START_SLOTS-1:0]   exp_start;
		logic                         exp_single;
	} row_t;

	logic                     x_clk;
	logic                     reset_;
	rx_mac_pkg::rx_mode_t     mode;
	logic                     init_done;
	rx_mac_pkg::xgmii_word_t  rx_in;
	rx_mac_pkg::xgmii_word_t  rx_out;
	logic                     x_we;
	rx_mac_pkg::bcnt_word_t   x_byte_cnt;
	logic                     x_bcnt_we;
	logic                     linkup;

	row_t                     table_q[$];
	rx_mac_pkg::xgmii_word_t  exp_words[$];
	rx_mac_pkg::bcnt_word_t   exp_recs[$];
	int                       exp_we_at[$];
	int                       exp_rec_at[$];
	int                       cyc = 0;
	logic [31:0]              rng = 32'h967d;
	int                       cycle_limit = 0;
	int                       word_errs = 0;
	int                       bcnt_errs = 0;
	int                       bit_errs = 0;
	int                       other_errs = 0;

	tb_clk_gen clk_gen_i (
		.x_clk  (x_clk),
		.reset_ (reset_)
	);

	rx_mac_top dut_i (
		.x_clk      (x_clk),
		.reset_     (reset_),
		.mode       (mode),
		.init_done  (init_done),
		.rx_in      (rx_in),
		.rx_out     (rx_out),
		.x_we       (x_we),
		.x_byte_cnt (x_byte_cnt),
		.x_bcnt_we  (x_bcnt_we),
		.linkup     (linkup)
	);

	//**********************************************************************
	// compare tasks
	//**********************************************************************
	task automatic check_word(input string name, input rx_mac_pkg::xgmii_word_t exp,
			input rx_mac_pkg::xgmii_word_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h got %h", name, exp, act);
			word_errs++;
		end
	endtask

	task automatic check_bcnt(input string name, input rx_mac_pkg::bcnt_word_t exp,
			input rx_mac_pkg::bcnt_word_t act);
		if (act !== exp) begin
			$display("ERR %s expected %h got %h", name, exp, act);
			bcnt_errs++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %s expected %h got %h", name, exp, act);
			bit_errs++;
		end
	endtask

	// a write is due OUT_LAT cycles after the first cycle of its beat
	task automatic check_timing(input string name, input int due);
		if (cyc != due) begin
			$display("%s came at cycle %0d instead of cycle %0d", name, cyc, due);
			other_errs++;
		end
	endtask

	//**********************************************************************
	// stimulus helpers
	//**********************************************************************
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// top bit cleared so never FB, FD or 9C
	function automatic logic [7:0] payload_byte();
		rng = xorshift32(rng);
		return rng[7:0] & 8'h7f;
	endfunction

	function automatic int hold_of(input rx_mac_pkg::rx_mode_t m);
		return (m == rx_mac_pkg::MODE_25G) ? `RX_HOLD_25G : `RX_HOLD_50G;
	endfunction

	function automatic rx_mac_pkg::xgmii_word_t idle_word();
		rx_mac_pkg::xgmii_word_t w;
		w.data = `RX_IDLE_DATA;
		w.ctrl = `RX_IDLE_CTRL;
		return w;
	endfunction

	// idle before the start lane, idle after the terminate lane, payload between
	function automatic rx_mac_pkg::xgmii_word_t build_beat(input int s_lane, input int t_lane);
		rx_mac_pkg::xgmii_word_t w;
		logic [7:0]              b;
		logic                    c;
		for (int i = 0; i < `RX_LANES; i++) begin
			if (s_lane >= 0 && i == s_lane) begin
				b = `RX_CODE_START;
				c = 1'b1;
			end else if (s_lane >= 0 && i < s_lane) begin
				b = 8'h07;
				c = 1'b1;
			end else if (t_lane >= 0 && i == t_lane) begin
				b = `RX_CODE_TERM;
				c = 1'b1;
			end else if (t_lane >= 0 && i > t_lane) begin
				b = 8'h07;
				c = 1'b1;
			end else begin
				b = payload_byte();
				c = 1'b0;
			end
			w.data[8*i +: 8] = b;
			w.ctrl[i]        = c;
		end
		return w;
	endfunction

	// local fault ordered set 9C 00 00 01
	function automatic rx_mac_pkg::xgmii_word_t fault_word(input int lane);
		rx_mac_pkg::xgmii_word_t w;
		w = idle_word();
		w.data[8*lane +: 32] = {8'h01, 8'h00, 8'h00, `RX_CODE_FAULT};
		w.ctrl[lane +: 4]    = 4'b0001;
		return w;
	endfunction

	task automatic next_cycle();
		@(posedge x_clk);
		#1;
	endtask

	task automatic drive_beat(input rx_mac_pkg::xgmii_word_t w, input int hold);
		repeat (hold) begin
			rx_in = w;
			next_cycle();
		end
	endtask

	// queue a beat with the cycle its write is due and drive it
	task automatic send_beat(input rx_mac_pkg::xgmii_word_t w, input int hold,
			input logic last);
		exp_words.push_back(w);
		exp_we_at.push_back(cyc + OUT_LAT);
		if (last) begin
			exp_rec_at.push_back(cyc + OUT_LAT);
		end
		drive_beat(w, hold);
	endtask

	task automatic add_row(input rx_mac_pkg::rx_mode_t m, input logic init, input int slot,
			input int mid, input logic same, input int term, input int fault,
			input int len, input logic [7:0] start, input logic single);
		row_t r;
		r.mode       = m;
		r.init_done  = init;
		r.start_slot = slot;
		r.mid_beats  = mid;
		r.same_beat  = same;
		r.term_lane  = term;
		r.fault_lane = fault;
		r.exp_len    = len[`RX_LEN_W-1:0];
		r.exp_start  = start;
		r.exp_single = single;
		table_q.push_back(r);
	endtask

	function automatic int row_cycles(input row_t r);
		int hold;
		int n;
		hold = hold_of(r.mode);
		n    = GAP_BEATS * hold;
		if (r.start_slot >= 0) begin
			n += hold * (r.same_beat ? 1 : r.mid_beats + 2);
		end else if (r.term_lane >= 0) begin
			n += hold;
		end
		if (r.fault_lane >= 0 || !r.init_done) begin
			n += FAULT_BEATS * hold + `RX_LINK_WAIT + 8;
		end
		return n;
	endfunction

	//**********************************************************************
	// row execution
	//**********************************************************************
	task automatic wait_link_up();
		int n;
		n = 0;
		while (linkup !== 1'b1 && n < `RX_LINK_WAIT + 8) begin
			next_cycle();
			n++;
		end
		check_bit("linkup", 1'b1, linkup);
		if (n < `RX_LINK_WAIT) begin
			$display("linkup rose after only %0d clean cycles", n);
			other_errs++;
		end
	endtask

	// fault sets or init_done low, then recovery
	task automatic link_event(input row_t r, input int hold);
		rx_mac_pkg::xgmii_word_t w;
		int                      fell;
		fell = 0;
		check_bit("linkup", 1'b1, linkup);
		w = (r.fault_lane >= 0) ? fault_word(r.fault_lane) : idle_word();
		init_done = r.init_done;
		for (int k = 1; k <= FAULT_BEATS * hold; k++) begin
			rx_in = w;
			next_cycle();
			if (fell == 0 && linkup === 1'b0) fell = k;
		end
		if (fell == 0 || fell > 3) begin
			$display("linkup did not fall within 3 cycles of the link event");
			other_errs++;
		end
		rx_in     = idle_word();
		init_done = 1'b1;
		wait_link_up();
	endtask

	task automatic send_frame(input row_t r, input int hold);
		rx_mac_pkg::xgmii_word_t w;
		rx_mac_pkg::bcnt_word_t  rec;
		if (r.start_slot >= 0) begin
			rec             = '0;
			rec.start_lane  = r.exp_start;
			rec.single_beat = r.exp_single;
			rec.length      = r.exp_len;
			exp_recs.push_back(rec);
			if (r.same_beat) begin
				w = build_beat(SLOT_LANES * r.start_slot, r.term_lane);
				send_beat(w, hold, 1'b1);
			end else begin
				w = build_beat(SLOT_LANES * r.start_slot, -1);
				send_beat(w, hold, 1'b0);
				repeat (r.mid_beats) begin
					w = build_beat(-1, -1);
					send_beat(w, hold, 1'b0);
				end
				w = build_beat(-1, r.term_lane);
				send_beat(w, hold, 1'b1);
			end
		end else if (r.term_lane >= 0) begin
			w = build_beat(-1, r.term_lane);   // stray terminate with nothing expected
			drive_beat(w, hold);
		end
	endtask

	task automatic run_row(input row_t r);
		int hold;
		hold = hold_of(r.mode);
		mode = r.mode;
		if (r.fault_lane >= 0 || !r.init_done) link_event(r, hold);
		send_frame(r, hold);
		drive_beat(idle_word(), GAP_BEATS * hold);
	endtask

	task automatic build_table();
		// mode, init, slot, mid, same, term, fault, len, start, single
		add_row(rx_mac_pkg::MODE_50G, 1, 0, 3, 0, 7, -1, 136, 8'h01, 0);
		add_row(rx_mac_pkg::MODE_25G, 1, 2, 2, 0, 15, -1, 104, 8'h04, 0);
		add_row(rx_mac_pkg::MODE_40G, 1, 1, 0, 0, 0, -1, 29, 8'h02, 0);
		add_row(rx_mac_pkg::MODE_50G, 1, 3, 1, 0, 31, -1, 84, 8'h08, 0);
		add_row(rx_mac_pkg::MODE_40G, 1, 4, 0, 0, 3, -1, 20, 8'h10, 0);
		add_row(rx_mac_pkg::MODE_25G, 1, 5, 1, 0, 20, -1, 65, 8'h20, 0);
		add_row(rx_mac_pkg::MODE_50G, 1, 6, 2, 0, 11, -1, 84, 8'h40, 0);
		add_row(rx_mac_pkg::MODE_50G, 1, 7, 0, 0, 26, -1, 31, 8'h80, 0);
		// single beat frames
		add_row(rx_mac_pkg::MODE_25G, 1, 0, 0, 1, 30, -1, 31, 8'h01, 1);
		add_row(rx_mac_pkg::MODE_50G, 1, 5, 0, 1, 27, -1, 8, 8'h20, 1);
		add_row(rx_mac_pkg::MODE_40G, 1, 2, 0, 1, 9, -1, 2, 8'h04, 1);
		// terminate outside a frame
		add_row(rx_mac_pkg::MODE_50G, 1, -1, 0, 0, 12, -1, 0, 8'h00, 0);
		add_row(rx_mac_pkg::MODE_25G, 1, -1, 0, 0, 0, -1, 0, 8'h00, 0);
		// link events
		add_row(rx_mac_pkg::MODE_50G, 1, -1, 0, 0, -1, 0, 0, 8'h00, 0);
		add_row(rx_mac_pkg::MODE_25G, 1, -1, 0, 0, -1, 4, 0, 8'h00, 0);
		add_row(rx_mac_pkg::MODE_50G, 0, -1, 0, 0, -1, -1, 0, 8'h00, 0);
		add_row(rx_mac_pkg::MODE_50G, 1, 0, 1, 0, 15, -1, 80, 8'h01, 0);
	endtask

	task automatic print_counts();
		$display("errors: rx_out %0d, x_byte_cnt %0d, level %0d, other %0d",
			word_errs, bcnt_errs, bit_errs, other_errs);
	endtask

	//**********************************************************************
	// output monitor sampling the registered outputs at each edge
	//**********************************************************************
	always @(posedge x_clk) begin
		if (reset_) begin
			if (x_we) begin
				if (exp_words.size() == 0) begin
					$display("x_we pulsed when no beat was expected");
					other_errs++;
				end else begin
					check_word("rx_out", exp_words.pop_front(), rx_out);
					check_timing("x_we", exp_we_at.pop_front());
				end
			end
			if (x_bcnt_we) begin
				if (exp_recs.size() == 0) begin
					$display("x_bcnt_we pulsed when no record was expected");
					other_errs++;
				end else begin
					check_bcnt("x_byte_cnt", exp_recs.pop_front(), x_byte_cnt);
					check_timing("x_bcnt_we", exp_rec_at.pop_front());
				end
			end
		end
		cyc++;
	end

	initial begin : watchdog
		@(posedge x_clk);
		for (int n = 0; n < cycle_limit; n++) @(posedge x_clk);
		$display("run stopped at the cycle limit of %0d, stimulus did not finish", cycle_limit);
		print_counts();
		$display("Testbench failed");
		$finish;
	end

	//**********************************************************************
	// main sequence
	//**********************************************************************
	initial begin : main
		int total;
		int n;
		rx_in     = idle_word();
		mode      = rx_mac_pkg::MODE_50G;
		init_done = 1'b0;
		build_table();
		total = 8 + `RX_LINK_WAIT + 8 + 16;
		foreach (table_q[i]) total += row_cycles(table_q[i]);
		cycle_limit = 2 * total;

		while (reset_ !== 1'b1) @(posedge x_clk);
		#1;
		check_bit("x_we", 1'b0, x_we);
		check_bit("x_bcnt_we", 1'b0, x_bcnt_we);
		check_bit("linkup", 1'b0, linkup);
		check_word("rx_out", idle_word(), rx_out);
		check_bcnt("x_byte_cnt", '0, x_byte_cnt);

		init_done = 1'b1;
		wait_link_up();

		for (int i = 0; i < table_q.size(); i++) begin
			run_row(table_q[i]);
		end

		// let the pipeline empty
		n = 0;
		while ((exp_words.size() != 0 || exp_recs.size() != 0) && n < 16) begin
			next_cycle();
			n++;
		end
		if (exp_words.size() != 0 || exp_recs.size() != 0) begin
			$display("%0d beats and %0d records were never written",
				exp_words.size(), exp_recs.size());
			other_errs++;
		end

		print_counts();
		if (word_errs + bcnt_errs + bit_errs + other_errs == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* verif/tb_clk_gen.sv */
//**************************************************************************
// 10 ns testbench clock, reset_ low for the first 8 rising edges
//**************************************************************************

module tb_clk_gen (
	output logic x_clk,
	output logic reset_
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int PERIOD      = 10;
	localparam int RESET_TICKS = 8;

	initial begin
		x_clk = 1'b0;
		forever #(PERIOD / 2) x_clk = ~x_clk;
	end

	// release just after an edge, like the other stimulus
	initial begin
		reset_ = 1'b0;
		repeat (RESET_TICKS) @(posedge x_clk);
		#1;
		reset_ = 1'b1;
	end

endmodule

/* rtl/rx_mac_top.sv */
//**************************************************************************
// receive MAC, 25G / 40G / 50G on a 256-bit bus with per-byte control
// each input beat must be held for the mode's hold count, no back-pressure
//**************************************************************************
`include "rx_mac_macros.svh"

module rx_mac_top (
	input  logic                     x_clk,
	input  logic                     reset_,
	input  rx_mac_pkg::rx_mode_t     mode,
	input  logic                     init_done,
	input  rx_mac_pkg::xgmii_word_t  rx_in,
	output rx_mac_pkg::xgmii_word_t  rx_out,
	output logic                     x_we,
	output rx_mac_pkg::bcnt_word_t   x_byte_cnt,
	output logic                     x_bcnt_we,
	output logic                     linkup
);

	rx_mac_pkg::xgmii_word_t  rx_dly;
	rx_mac_pkg::xgmii_word_t  word_cap;
	rx_mac_pkg::lane_flags_t  flags;
	rx_mac_pkg::bcnt_word_t   bcnt;
	logic                     beat_sample;
	logic                     restart;
	logic                     in_frame;
	logic                     frame_end;
	logic                     beat_we;
	logic                     bcnt_we;
	logic                     link_ok;

	// a start seen while idle realigns the beat phase
	assign restart = (|flags.start) & ~in_frame;

	rx_lane_decode u_decode (
		.x_clk  (x_clk),
		.reset_ (reset_),
		.rx_in  (rx_in),
		.rx_dly (rx_dly),
		.flags  (flags)
	);

	rx_beat_pacer u_pacer (
		.x_clk       (x_clk),
		.reset_      (reset_),
		.mode        (mode),
		.restart     (restart),
		.beat_sample (beat_sample)
	);

	rx_framer u_framer (
		.x_clk       (x_clk),
		.reset_      (reset_),
		.rx_dly      (rx_dly),
		.flags       (flags),
		.beat_sample (beat_sample),
		.in_frame    (in_frame),
		.frame_end   (frame_end),
		.beat_we     (beat_we),
		.word_out    (word_cap)
	);

	rx_byte_counter u_bcnt (
		.x_clk       (x_clk),
		.reset_      (reset_),
		.flags       (flags),
		.beat_sample (beat_sample),
		.in_frame    (in_frame),
		.frame_end   (frame_end),
		.bcnt        (bcnt),
		.bcnt_we     (bcnt_we)
	);

	rx_link_monitor u_link (
		.x_clk     (x_clk),
		.reset_    (reset_),
		.init_done (init_done),
		.fault     (flags.fault),
		.linkup    (link_ok)
	);

	//**********************************************************************
	// output stage toward the FIFOs
	//**********************************************************************
	always_ff @(posedge x_clk) begin
		if (!reset_) begin
			rx_out     <= '{data: `RX_IDLE_DATA, ctrl: `RX_IDLE_CTRL};
			x_we       <= 1'b0;
			x_byte_cnt <= '0;
			x_bcnt_we  <= 1'b0;
			linkup     <= 1'b0;
		end else begin
			rx_out     <= word_cap;
			x_we       <= beat_we;
			x_byte_cnt <= bcnt;
			x_bcnt_we  <= bcnt_we;
			linkup     <= link_ok;
		end
	end

endmodule

/* rtl/rx_link_monitor.sv */
//**************************************************************************
// link state from local fault sets and init_done
// linkup needs RX_LINK_WAIT clean cycles in a row after the last fault
//**************************************************************************
`include "rx_mac_macros.svh"

module rx_link_monitor (
	input  logic x_clk,
	input  logic reset_,
	input  logic init_done,
	input  logic fault,
	output logic linkup
);

	localparam int CNT_W = $clog2(`RX_LINK_WAIT + 1);

	rx_mac_pkg::link_state_t state;
	logic [CNT_W-1:0]        wait_cnt;
	logic                    link_bad;

	assign link_bad = fault | ~init_done;
	assign linkup   = (state == rx_mac_pkg::LINK_GOOD);

	//**********************************************************************
	// fail / recover / good
	//**********************************************************************
	always_ff @(posedge x_clk) begin
		if (!reset_) begin
			state    <= rx_mac_pkg::LINK_FAIL;
			wait_cnt <= CNT_W'(`RX_LINK_WAIT);
		end else begin
			case (state)
				rx_mac_pkg::LINK_FAIL: begin
					wait_cnt <= CNT_W'(`RX_LINK_WAIT);
					if (!link_bad) state <= rx_mac_pkg::LINK_RCVR;
				end
				rx_mac_pkg::LINK_RCVR: begin
					if (link_bad) begin
						state <= rx_mac_pkg::LINK_FAIL;
					end else if (wait_cnt == CNT_W'(1)) begin
						state <= rx_mac_pkg::LINK_GOOD;   // last clean cycle
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				rx_mac_pkg::LINK_GOOD: begin
					if (link_bad) state <= rx_mac_pkg::LINK_FAIL;
				end
				default: begin
					state <= rx_mac_pkg::LINK_FAIL;
				end
			endcase
		end
	end

endmodule

/* rtl/frame/rx_byte_counter.sv */
//**************************************************************************
// frame length and start slot, record valid with bcnt_we at frame end
// only the lowest start slot and lowest terminate lane of a beat count
//**************************************************************************
`include "rx_mac_macros.svh"

module rx_byte_counter (
	input  logic                     x_clk,
	input  logic                     reset_,
	input  rx_mac_pkg::lane_flags_t  flags,
	input  logic                     beat_sample,
	input  logic                     in_frame,
	input  logic                     frame_end,
	output rx_mac_pkg::bcnt_word_t   bcnt,
	output logic                     bcnt_we
);

	localparam int LANES      = `RX_LANES;
	localparam int SLOTS      = `RX_START_SLOTS;
	localparam int SLOT_LANES = LANES / SLOTS;
	localparam int SLOT_W     = $clog2(SLOTS);
	localparam int LANE_W     = $clog2(LANES);
	localparam int LEN_W      = `RX_LEN_W;

	logic              has_start;
	logic              has_term;
	logic              take_beat;
	logic [SLOT_W-1:0] start_slot;
	logic [LANE_W-1:0] term_lane;
	logic [SLOTS-1:0]  start_hot;
	logic [SLOTS-1:0]  slot_q;      // start slot of the open frame
	logic [LEN_W-1:0]  start_off;
	logic [LEN_W-1:0]  head_len;
	logic [LEN_W-1:0]  tail_len;
	logic [LEN_W-1:0]  len_acc;

	assign has_start = |flags.start;
	assign has_term  = |flags.term;
	assign take_beat = beat_sample & (in_frame | has_start);

	// lowest set bit wins
	assign start_hot = flags.start & (~flags.start + 1'b1);

	always_comb begin
		start_slot = '0;
		term_lane  = '0;
		for (int s = SLOTS - 1; s >= 0; s--) begin
			if (flags.start[s]) start_slot = SLOT_W'(s);
		end
		for (int i = LANES - 1; i >= 0; i--) begin
			if (flags.term[i]) term_lane = LANE_W'(i);
		end
	end

	assign start_off = LEN_W'(SLOT_LANES * start_slot);
	assign head_len  = LEN_W'(LANES) - start_off;     // bytes from start lane on
	assign tail_len  = LEN_W'(term_lane) + 1'b1;      // bytes up to terminate

	//**********************************************************************
	// accumulate and build the record
	//**********************************************************************
	always_ff @(posedge x_clk) begin
		if (!reset_) begin
			len_acc <= '0;
			slot_q  <= '0;
			bcnt    <= '0;
		end else if (take_beat) begin
			if (!in_frame) begin
				len_acc <= head_len;
				slot_q  <= start_hot;
				if (has_term) begin
					bcnt <= '{start_lane: start_hot, single_beat: 1'b1,
						spare: '0, length: tail_len - start_off};
				end
			end else if (has_term) begin
				bcnt <= '{start_lane: slot_q, single_beat: 1'b0,
					spare: '0, length: len_acc + tail_len};
			end else begin
				len_acc <= len_acc + LEN_W'(LANES);  // full middle beat
			end
		end
	end

	// record lands in the same cycle as the framer's end pulse
	assign bcnt_we = frame_end;

endmodule

/* rtl/frame/rx_framer.sv */
//**************************************************************************
// frame state and beat capture, one write per sampled beat in a frame
// terminate is ignored unless a frame is open or starts in the same beat
//**************************************************************************
`include "rx_mac_macros.svh"

module rx_framer (
	input  logic                     x_clk,
	input  logic                     reset_,
	input  rx_mac_pkg::xgmii_word_t  rx_dly,
	input  rx_mac_pkg::lane_flags_t  flags,
	input  logic                     beat_sample,
	output logic                     in_frame,
	output logic                     frame_end,
	output logic                     beat_we,
	output rx_mac_pkg::xgmii_word_t  word_out
);

	logic has_start;
	logic has_term;
	logic take_beat;

	assign has_start = |flags.start;
	assign has_term  = |flags.term;

	// start beat, middle beats and end beat all get written
	assign take_beat = beat_sample & (in_frame | has_start);

	//**********************************************************************
	// frame bit and capture
	//**********************************************************************
	always_ff @(posedge x_clk) begin
		if (!reset_) begin
			in_frame  <= 1'b0;
			frame_end <= 1'b0;
			beat_we   <= 1'b0;
			word_out  <= '{data: `RX_IDLE_DATA, ctrl: `RX_IDLE_CTRL};
		end else begin
			beat_we   <= take_beat;
			frame_end <= take_beat & has_term;     // also for start+term beat
			if (take_beat) begin
				word_out <= rx_dly;                // held until next write
				in_frame <= ~has_term;
			end
		end
	end

endmodule

/* rtl/frame/rx_beat_pacer.sv */
//**************************************************************************
// marks the one sampled cycle of each held beat
// mode must be static, restart realigns the phase to a new start beat
//**************************************************************************
`include "rx_mac_macros.svh"

module rx_beat_pacer (
	input  logic                  x_clk,
	input  logic                  reset_,
	input  rx_mac_pkg::rx_mode_t  mode,
	input  logic                  restart,
	output logic                  beat_sample
);

	localparam logic [1:0] LAST_25G = 2'(`RX_HOLD_25G - 1);
	localparam logic [1:0] LAST_50G = 2'(`RX_HOLD_50G - 1);

	logic [1:0] phase;
	logic [1:0] phase_now;
	logic [1:0] last_phase;
	logic       restart_q;
	logic       restart_edge;

	// a single-beat frame keeps restart high for the whole hold
	assign restart_edge = restart & ~restart_q;
	assign phase_now    = restart_edge ? 2'd0 : phase;
	assign last_phase   = (mode == rx_mac_pkg::MODE_25G) ? LAST_25G : LAST_50G;
	assign beat_sample  = (phase_now == 2'd0);

	always_ff @(posedge x_clk) begin
		if (!reset_) begin
			phase     <= 2'd0;
			restart_q <= 1'b0;
		end else begin
			restart_q <= restart;
			phase     <= (phase_now == last_phase) ? 2'd0 : phase_now + 2'd1;
		end
	end

endmodule

/* rtl/frame/rx_lane_decode.sv */
//**************************************************************************
// registers the receive bus and decodes control characters per lane
// fault ordered sets are only recognised at lanes 0 and 4
//**************************************************************************
`include "rx_mac_macros.svh"

module rx_lane_decode (
	input  logic                     x_clk,
	input  logic                     reset_,
	input  rx_mac_pkg::xgmii_word_t  rx_in,
	output rx_mac_pkg::xgmii_word_t  rx_dly,
	output rx_mac_pkg::lane_flags_t  flags
);

	localparam int LANES      = `RX_LANES;
	localparam int SLOTS      = `RX_START_SLOTS;
	localparam int SLOT_LANES = LANES / SLOTS;

	rx_mac_pkg::lane_flags_t flags_nxt;

	//**********************************************************************
	// lane compares
	//**********************************************************************
	always_comb begin
		flags_nxt = '0;

		// terminate may sit in any lane
		for (int i = 0; i < LANES; i++) begin
			flags_nxt.term[i] = rx_in.ctrl[i] &
				(rx_in.data[8*i +: 8] == `RX_CODE_TERM);
		end

		// start only at the first lane of a slot
		for (int s = 0; s < SLOTS; s++) begin
			flags_nxt.start[s] = rx_in.ctrl[s*SLOT_LANES] &
				(rx_in.data[8*s*SLOT_LANES +: 8] == `RX_CODE_START);
		end

		// each fault code checked against its own control bit
		flags_nxt.fault =
			(rx_in.ctrl[0] & (rx_in.data[7:0] == `RX_CODE_FAULT)) |
			(rx_in.ctrl[SLOT_LANES] &
				(rx_in.data[8*SLOT_LANES +: 8] == `RX_CODE_FAULT));
	end

	// payload stage
	always_ff @(posedge x_clk) begin
		rx_dly <= rx_in;
	end

	always_ff @(posedge x_clk) begin
		if (!reset_) begin
			flags <= '0;
		end else begin
			flags <= flags_nxt;
		end
	end

endmodule

/* common/rx_mac_pkg.sv */
//**************************************************************************
// shared types of the receive MAC
// bcnt_word_t keeps the byte count record layout of the downstream FIFO
//**************************************************************************
`include "rx_mac_macros.svh"

package rx_mac_pkg;

	// rate select, static while traffic runs
	typedef enum logic [1:0] {
		MODE_25G,
		MODE_40G,
		MODE_50G
	} rx_mode_t;

	// link monitor states
	typedef enum logic [1:0] {
		LINK_FAIL,
		LINK_RCVR,
		LINK_GOOD
	} link_state_t;

	// one bus beat, data above control
	typedef struct packed {
		logic [`RX_DATA_W-1:0] data;
		logic [`RX_LANES-1:0]  ctrl;
	} xgmii_word_t;

	// per lane decode results
	typedef struct packed {
		logic [`RX_START_SLOTS-1:0] start;   // one per start slot
		logic [`RX_LANES-1:0]       term;    // one per lane
		logic                       fault;   // lanes 0 and 4 only
	} lane_flags_t;

	// byte count record, 32 bits
	typedef struct packed {
		logic [`RX_START_SLOTS-1:0] start_lane;  // one-hot start slot
		logic                       single_beat;
		logic [6:0]                 spare;
		logic [`RX_LEN_W-1:0]       length;
	} bcnt_word_t;

endpackage

/* common/rx_mac_macros.svh */
//**************************************************************************
// widths, control codes and timing constants for the 256-bit receive MAC
// hold counts assume the PHY repeats each bus beat for a whole beat period
//**************************************************************************
`ifndef RX_MAC_MACROS_SVH
`define RX_MAC_MACROS_SVH

// bus geometry
`define RX_DATA_W       256
`define RX_LANES        32
`define RX_START_SLOTS  8         // start allowed at every fourth lane

// control characters, valid only with the lane's control bit set
`define RX_CODE_START   8'hFB
`define RX_CODE_TERM    8'hFD
`define RX_CODE_FAULT   8'h9C     // local fault ordered set

// idle bus
`define RX_IDLE_DATA    {`RX_LANES{8'h07}}
`define RX_IDLE_CTRL    {`RX_LANES{1'b1}}

// clocks per held beat
`define RX_HOLD_25G     4
`define RX_HOLD_50G     2         // 40G uses the same hold

// link recovery
`define RX_LINK_WAIT    8         // clean cycles before linkup

// byte count record
`define RX_LEN_W        16

`endif
